/* gpu_isa_pkg.sv */
/*
  Instruction set definitions shared by the operand stage and its testbench.
  Holds the opcodes, register and warp widths, and the issued instruction.
*/
package gpu_isa_pkg;

  localparam int NUM_BANKS = 4;

  typedef logic [1:0]  warp_num_t;
  typedef logic [4:0]  reg_num_t;
  typedef logic [31:0] word_t;

  typedef enum logic [2:0] {
    OP_LI    = 3'd0,
    OP_ADD   = 3'd1,
    OP_SUB   = 3'd2,
    OP_AND   = 3'd3,
    OP_XOR   = 3'd4,
    OP_LOAD  = 3'd5,
    OP_STORE = 3'd6
  } opcode_t;

  typedef struct packed {
    warp_num_t   warp;
    opcode_t     opcode;
    reg_num_t    rd;
    reg_num_t    rs1;
    reg_num_t    rs2;
    logic [15:0] imm;
  } issue_inst_t;

  // Immediate as seen by li and by load/store addressing
  function automatic word_t sext_imm(logic [15:0] imm);
    return {{16{imm[15]}}, imm};
  endfunction

endpackage

/* gpu_pipe_pkg.sv */
/*
  Microarchitecture types of the operand stage: bank addresses, collector
  requests and responses, dispatched instructions and writeback results.
*/
package gpu_pipe_pkg;
  import gpu_isa_pkg::*;

  typedef struct packed {
    logic [1:0] bank;
    logic [4:0] row;
  } bank_addr_t;

  typedef enum logic {
    UNIT_ALU = 1'b0,
    UNIT_LSU = 1'b1
  } unit_t;

  typedef logic [1:0] collector_idx_t;

  // Source arrays are indexed by operand slot, 0 for rs1 and 1 for rs2
  typedef struct packed {
    issue_inst_t      inst;
    unit_t            unit;
    bank_addr_t [1:0] src_addr;
    logic [1:0]       needs_fetch;
  } decoded_inst_t;

  typedef struct packed {
    logic [NUM_BANKS-1:0]           valid;
    logic [NUM_BANKS-1:0][4:0]      row;
    collector_idx_t [NUM_BANKS-1:0] idx;
    logic [NUM_BANKS-1:0]           slot;
  } read_req_t;

  typedef struct packed {
    logic [NUM_BANKS-1:0]           valid;
    word_t [NUM_BANKS-1:0]          data;
    collector_idx_t [NUM_BANKS-1:0] idx;
    logic [NUM_BANKS-1:0]           slot;
  } read_resp_t;

  typedef struct packed {
    warp_num_t   warp;
    opcode_t     opcode;
    reg_num_t    rd;
    logic [15:0] imm;
    word_t       src1;
    word_t       src2;
  } exec_inst_t;

  typedef struct packed {
    warp_num_t warp;
    reg_num_t  rd;
    word_t     data;
  } result_t;

  // Bank rotates with the warp so that warps spread their registers over the banks
  function automatic bank_addr_t bank_map(warp_num_t warp, reg_num_t rnum);
    bank_addr_t a;
    a.bank = rnum[4:3] + warp;
    a.row  = {warp, rnum[2:0]};
    return a;
  endfunction

endpackage

/* inst_decoder.sv */
/*
  Combinational decode of an issued instruction. Picks the execution unit
  and maps both sources onto a register bank and row.
*/
module inst_decoder
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
(
  input  issue_inst_t   inst,
  output decoded_inst_t decoded
);

  logic reads_rs1;
  logic reads_rs2;

  always_comb begin
    reads_rs1 = (inst.opcode != OP_LI);
    reads_rs2 = !(inst.opcode inside {OP_LI, OP_LOAD});
  end

  always_comb begin
    decoded.inst = inst;
    decoded.unit = (inst.opcode inside {OP_LOAD, OP_STORE}) ? UNIT_LSU : UNIT_ALU;
    decoded.src_addr[0] = bank_map(inst.warp, inst.rs1);
    decoded.src_addr[1] = bank_map(inst.warp, inst.rs2);
    // Register 0 is hardwired to zero, nothing to fetch
    decoded.needs_fetch[0] = reads_rs1 && (inst.rs1 != '0);
    decoded.needs_fetch[1] = reads_rs2 && (inst.rs2 != '0);
  end

endmodule

/* operand_collector.sv */
/*
  Operand collector. Holds issued instructions, fetches their sources from
  the banked register file one entry per cycle, and dispatches ready
  entries to the ALU and the load/store unit.
*/
module operand_collector
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
#(
  parameter int DEPTH = 4
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          issue_valid,
  output logic          issue_ready,
  input  decoded_inst_t decoded,
  output read_req_t     read_req,
  input  read_resp_t    read_resp,
  input  logic          alu_busy,
  input  logic          lsu_busy,
  output logic          alu_valid,
  output logic          lsu_valid,
  output exec_inst_t    alu_inst,
  output exec_inst_t    lsu_inst
);

  // Per slot, fetched means data is held and pending means a read is in flight
  typedef struct packed {
    logic       valid;
    logic [1:0] fetched;
    logic [1:0] pending;
  } entry_ctrl_t;

  entry_ctrl_t   ctrl   [DEPTH];
  decoded_inst_t inst_q [DEPTH];
  word_t [1:0]   data_q [DEPTH];

  logic           full;
  logic           alloc;
  collector_idx_t alloc_idx;
  collector_idx_t rr_ptr;
  logic           pick_found;
  collector_idx_t pick_idx;
  logic [1:0]     req_go;
  logic           alu_go;
  logic           lsu_go;
  collector_idx_t alu_idx;
  collector_idx_t lsu_idx;

  function automatic exec_inst_t to_exec(decoded_inst_t d, word_t [1:0] src);
    exec_inst_t x;
    x.warp   = d.inst.warp;
    x.opcode = d.inst.opcode;
    x.rd     = d.inst.rd;
    x.imm    = d.inst.imm;
    x.src1   = src[0];
    x.src2   = src[1];
    return x;
  endfunction

  // Lowest free entry
  always_comb begin
    full      = 1'b1;
    alloc_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (!ctrl[i].valid) begin
        full      = 1'b0;
        alloc_idx = collector_idx_t'(i);
      end
    end
  end

  assign issue_ready = !full;
  assign alloc       = issue_valid && !full;

  // Round robin over entries that still have an operand to request
  always_comb begin
    int e;
    pick_found = 1'b0;
    pick_idx   = '0;
    for (int k = DEPTH - 1; k >= 0; k--) begin
      e = (int'(rr_ptr) + k) % DEPTH;
      if (ctrl[e].valid && |(~ctrl[e].fetched & ~ctrl[e].pending)) begin
        pick_found = 1'b1;
        pick_idx   = collector_idx_t'(e);
      end
    end
  end

  always_comb begin
    bank_addr_t a;
    logic       same_bank;
    same_bank = (inst_q[pick_idx].src_addr[0].bank == inst_q[pick_idx].src_addr[1].bank);
    req_go[0] = pick_found && !ctrl[pick_idx].fetched[0] && !ctrl[pick_idx].pending[0];
    // Operand 2 waits a round when it shares a bank with operand 1
    req_go[1] = pick_found && !ctrl[pick_idx].fetched[1] && !ctrl[pick_idx].pending[1] &&
                !(req_go[0] && same_bank);
    read_req = '0;
    for (int s = 0; s < 2; s++) begin
      a = inst_q[pick_idx].src_addr[s];
      if (req_go[s]) begin
        read_req.valid[a.bank] = 1'b1;
        read_req.row[a.bank]   = a.row;
        read_req.idx[a.bank]   = pick_idx;
        read_req.slot[a.bank]  = 1'(s);
      end
    end
  end

  // Lowest ready entry per unit; a unit whose pulse is out is not yet busy
  always_comb begin
    alu_go  = 1'b0;
    lsu_go  = 1'b0;
    alu_idx = '0;
    lsu_idx = '0;
    for (int i = DEPTH - 1; i >= 0; i--) begin
      if (ctrl[i].valid && &ctrl[i].fetched) begin
        if (inst_q[i].unit == UNIT_ALU) begin
          alu_go  = 1'b1;
          alu_idx = collector_idx_t'(i);
        end else begin
          lsu_go  = 1'b1;
          lsu_idx = collector_idx_t'(i);
        end
      end
    end
    alu_go = alu_go && !alu_busy && !alu_valid;
    lsu_go = lsu_go && !lsu_busy && !lsu_valid;
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        ctrl[i] <= '0;
      end
      rr_ptr    <= '0;
      alu_valid <= 1'b0;
      lsu_valid <= 1'b0;
    end else begin
      alu_valid <= alu_go;
      lsu_valid <= lsu_go;
      if (pick_found) begin
        rr_ptr <= collector_idx_t'((int'(pick_idx) + 1) % DEPTH);
      end
      for (int s = 0; s < 2; s++) begin
        if (req_go[s]) begin
          ctrl[pick_idx].pending[s] <= 1'b1;
        end
      end
      for (int b = 0; b < NUM_BANKS; b++) begin
        if (read_resp.valid[b]) begin
          ctrl[read_resp.idx[b]].fetched[read_resp.slot[b]] <= 1'b1;
          ctrl[read_resp.idx[b]].pending[read_resp.slot[b]] <= 1'b0;
        end
      end
      if (alu_go) begin
        ctrl[alu_idx].valid <= 1'b0;
      end
      if (lsu_go) begin
        ctrl[lsu_idx].valid <= 1'b0;
      end
      if (alloc) begin
        ctrl[alloc_idx].valid   <= 1'b1;
        ctrl[alloc_idx].fetched <= ~decoded.needs_fetch;
        ctrl[alloc_idx].pending <= '0;
      end
    end
  end

  // Unfetched sources stay zero, which covers register 0
  always_ff @(posedge clk) begin
    if (alloc) begin
      inst_q[alloc_idx] <= decoded;
      data_q[alloc_idx] <= '0;
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (read_resp.valid[b]) begin
        data_q[read_resp.idx[b]][read_resp.slot[b]] <= read_resp.data[b];
      end
    end
    if (alu_go) begin
      alu_inst <= to_exec(inst_q[alu_idx], data_q[alu_idx]);
    end
    if (lsu_go) begin
      lsu_inst <= to_exec(inst_q[lsu_idx], data_q[lsu_idx]);
    end
  end

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_resp_check
    assert property (@(posedge clk) disable iff (!rst_n)
      read_resp.valid[b] |-> ctrl[read_resp.idx[b]].valid &&
                             ctrl[read_resp.idx[b]].pending[read_resp.slot[b]])
      else $error("bank %0d response for an idle collector entry", b);
  end

endmodule

/* register_banks.sv */
/*
  Four-bank register file for all warps. Each bank serves one registered
  read per cycle and takes writes from the writeback stream.
*/
module register_banks
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  read_req_t  read_req,
  output read_resp_t read_resp,
  input  logic       wr_valid,
  input  result_t    wr_result
);

  localparam int ROWS = 32;

  word_t      mem [NUM_BANKS][ROWS];
  bank_addr_t wr_addr;

  assign wr_addr = bank_map(wr_result.warp, wr_result.rd);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        for (int r = 0; r < ROWS; r++) begin
          mem[b][r] <= '0;
        end
      end
    end else if (wr_valid && wr_result.rd != '0) begin
      mem[wr_addr.bank][wr_addr.row] <= wr_result.data;
    end
  end

  // Same-cycle write is not forwarded, it shows on the next request
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      read_resp <= '0;
    end else begin
      for (int b = 0; b < NUM_BANKS; b++) begin
        read_resp.valid[b] <= read_req.valid[b];
        if (read_req.valid[b]) begin
          read_resp.data[b] <= mem[b][read_req.row[b]];
          read_resp.idx[b]  <= read_req.idx[b];
          read_resp.slot[b] <= read_req.slot[b];
        end
      end
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) wr_valid |-> wr_result.rd != '0)
    else $error("writeback to register 0, warp %0d", wr_result.warp);

endmodule

/* alu_unit.sv */
/*
  Integer ALU. Computes in the dispatch cycle and holds the result
  until the writeback arbiter takes it.
*/
module alu_unit
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       dispatch,
  input  exec_inst_t inst,
  output logic       busy,
  output logic       result_valid,
  output result_t    result,
  input  logic       result_taken
);

  word_t value;

  always_comb begin
    case (inst.opcode)
      OP_LI:   value = sext_imm(inst.imm);
      OP_ADD:  value = inst.src1 + inst.src2;
      OP_SUB:  value = inst.src1 - inst.src2;
      OP_AND:  value = inst.src1 & inst.src2;
      OP_XOR:  value = inst.src1 ^ inst.src2;
      default: value = '0;
    endcase
  end

  assign busy = result_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      result_valid <= 1'b0;
    end else if (dispatch) begin
      result_valid <= 1'b1;
    end else if (result_taken) begin
      result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      result.warp <= inst.warp;
      result.rd   <= inst.rd;
      result.data <= value;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n) dispatch |-> !busy)
    else $error("ALU dispatch while a result is still held");

endmodule

/* load_store_unit.sv */
/*
  Load/store unit with a private data memory. An access is staged for one
  cycle: a store writes then, a load returns its word a cycle later.
*/
module load_store_unit
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
#(
  parameter int MEM_WORDS = 64
) (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       dispatch,
  input  exec_inst_t inst,
  output logic       busy,
  output logic       result_valid,
  output result_t    result,
  input  logic       result_taken
);

  localparam int AW = $clog2(MEM_WORDS);

  typedef struct packed {
    logic          load;
    logic [AW-1:0] addr;
    word_t         data;
    warp_num_t     warp;
    reg_num_t      rd;
  } stage_t;

  word_t  mem [MEM_WORDS];
  word_t  eff_addr;
  logic   stage_valid;
  stage_t stage;

  assign eff_addr = (inst.src1 + sext_imm(inst.imm)) % MEM_WORDS;
  assign busy     = stage_valid || result_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage_valid  <= 1'b0;
      result_valid <= 1'b0;
      for (int i = 0; i < MEM_WORDS; i++) begin
        mem[i] <= '0;
      end
    end else begin
      stage_valid <= dispatch;
      if (stage_valid && stage.load) begin
        result_valid <= 1'b1;
      end else if (result_taken) begin
        result_valid <= 1'b0;
      end
      if (stage_valid && !stage.load) begin
        mem[stage.addr] <= stage.data;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (dispatch) begin
      stage.load <= (inst.opcode == OP_LOAD);
      stage.addr <= AW'(eff_addr);
      stage.data <= inst.src2;
      stage.warp <= inst.warp;
      stage.rd   <= inst.rd;
    end
    if (stage_valid && stage.load) begin
      result.warp <= stage.warp;
      result.rd   <= stage.rd;
      result.data <= mem[stage.addr];
    end
  end

endmodule

/* writeback_arbiter.sv */
/*
  Merges ALU and load results into one register write per cycle.
  Loads win; the granted result is registered onto the writeback port.
*/
module writeback_arbiter
  import gpu_pipe_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    alu_valid,
  input  logic    lsu_valid,
  input  result_t alu_result,
  input  result_t lsu_result,
  output logic    alu_taken,
  output logic    lsu_taken,
  output logic    wb_valid,
  output result_t wb_result
);

  assign lsu_taken = lsu_valid;
  assign alu_taken = alu_valid && !lsu_valid;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= alu_valid || lsu_valid;
    end
  end

  always_ff @(posedge clk) begin
    if (lsu_valid) begin
      wb_result <= lsu_result;
    end else if (alu_valid) begin
      wb_result <= alu_result;
    end
  end

endmodule

/* gpu_operand_top.sv */
/*
  Operand stage top level: decoder, operand collector, banked register file,
  ALU, load/store unit and writeback arbiter.
*/
module gpu_operand_top
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
#(
  parameter int COLLECTOR_DEPTH = 4,
  parameter int MEM_WORDS       = 64
) (
  input  logic        clk,
  input  logic        rst_n,
  input  logic        issue_valid,
  input  issue_inst_t issue_inst,
  output logic        issue_ready,
  output logic        wb_valid,
  output result_t     wb_result
);

  decoded_inst_t decoded;
  read_req_t     read_req;
  read_resp_t    read_resp;
  logic          alu_dispatch;
  logic          lsu_dispatch;
  exec_inst_t    alu_inst;
  exec_inst_t    lsu_inst;
  logic          alu_busy;
  logic          lsu_busy;
  logic          alu_result_valid;
  logic          lsu_result_valid;
  result_t       alu_result;
  result_t       lsu_result;
  logic          alu_taken;
  logic          lsu_taken;

  inst_decoder u_decoder (
    .inst    (issue_inst),
    .decoded (decoded)
  );

  operand_collector #(
    .DEPTH (COLLECTOR_DEPTH)
  ) u_collector (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_ready (issue_ready),
    .decoded     (decoded),
    .read_req    (read_req),
    .read_resp   (read_resp),
    .alu_busy    (alu_busy),
    .lsu_busy    (lsu_busy),
    .alu_valid   (alu_dispatch),
    .lsu_valid   (lsu_dispatch),
    .alu_inst    (alu_inst),
    .lsu_inst    (lsu_inst)
  );

  register_banks u_banks (
    .clk       (clk),
    .rst_n     (rst_n),
    .read_req  (read_req),
    .read_resp (read_resp),
    .wr_valid  (wb_valid),
    .wr_result (wb_result)
  );

  alu_unit u_alu (
    .clk          (clk),
    .rst_n        (rst_n),
    .dispatch     (alu_dispatch),
    .inst         (alu_inst),
    .busy         (alu_busy),
    .result_valid (alu_result_valid),
    .result       (alu_result),
    .result_taken (alu_taken)
  );

  load_store_unit #(
    .MEM_WORDS (MEM_WORDS)
  ) u_lsu (
    .clk          (clk),
    .rst_n        (rst_n),
    .dispatch     (lsu_dispatch),
    .inst         (lsu_inst),
    .busy         (lsu_busy),
    .result_valid (lsu_result_valid),
    .result       (lsu_result),
    .result_taken (lsu_taken)
  );

  writeback_arbiter u_wb_arb (
    .clk        (clk),
    .rst_n      (rst_n),
    .alu_valid  (alu_result_valid),
    .lsu_valid  (lsu_result_valid),
    .alu_result (alu_result),
    .lsu_result (lsu_result),
    .alu_taken  (alu_taken),
    .lsu_taken  (lsu_taken),
    .wb_valid   (wb_valid),
    .wb_result  (wb_result)
  );

endmodule

/* tb_gpu_operand.sv */
/*
  Testbench for the operand stage. Plays the warp scheduler, keeps a register
  and memory model updated at issue time, and checks every writeback with
  concurrent assertions. Compile with all.f, top module tb_gpu_operand.
*/
module tb_gpu_operand
  import gpu_isa_pkg::*;
  import gpu_pipe_pkg::*;
();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int WAIT_LIMIT = 200;
  localparam int MEM_WORDS  = 64;

  logic        clk;
  logic        rst_n;
  logic        issue_valid;
  issue_inst_t issue_inst;
  logic        issue_ready;
  logic        wb_valid;
  result_t     wb_result;

  word_t       model_reg [4][32];
  word_t       model_mem [MEM_WORDS];
  logic        pend [4][32];
  logic        exp_pend;
  word_t       exp_data;
  logic [31:0] rng_state = 32'h7645_61e6;
  int          exp_count = 0;
  int          wb_count = 0;
  int          value_errors = 0;
  int          unexpected_errors = 0;
  int          count_errors = 0;
  int          ready_errors = 0;
  logic        ready_low_seen = 1'b0;
  logic        timed_out = 1'b0;

  // Sources span all four bank offsets
  reg_num_t src_regs [7] = '{5'd1, 5'd2, 5'd3, 5'd9, 5'd10, 5'd17, 5'd25};
  opcode_t  alu_ops  [4] = '{OP_ADD, OP_SUB, OP_AND, OP_XOR};

  gpu_operand_top #(
    .COLLECTOR_DEPTH (4),
    .MEM_WORDS       (MEM_WORDS)
  ) u_dut (
    .clk         (clk),
    .rst_n       (rst_n),
    .issue_valid (issue_valid),
    .issue_inst  (issue_inst),
    .issue_ready (issue_ready),
    .wb_valid    (wb_valid),
    .wb_result   (wb_result)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign exp_pend = pend[wb_result.warp][wb_result.rd];
  assign exp_data = model_reg[wb_result.warp][wb_result.rd];

  always @(posedge clk) begin
    if (rst_n && wb_valid) begin
      pend[wb_result.warp][wb_result.rd] = 1'b0;
      wb_count <= wb_count + 1;
    end
    if (rst_n && !issue_ready) begin
      ready_low_seen = 1'b1;
    end
  end

  wb_expected: assert property (@(posedge clk) disable iff (!rst_n) wb_valid |-> exp_pend)
    else begin
      unexpected_errors++;
      $display("Writeback at %0t to warp %0d register %0d that has no instruction in flight",
               $time, $sampled(wb_result.warp), $sampled(wb_result.rd));
    end

  wb_value: assert property (@(posedge clk) disable iff (!rst_n)
    wb_valid |-> wb_result.data == exp_data)
    else begin
      value_errors++;
      $display("FAIL %0t wb_result.data expected %h got %h",
               $time, $sampled(exp_data), $sampled(wb_result.data));
    end

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  function automatic word_t sign_extend16(input logic [15:0] v);
    return {{16{v[15]}}, v};
  endfunction

  task automatic print_counts();
    $display("errors: value %0d, unexpected writeback %0d, writeback count %0d, %s %0d, %s %0d",
             value_errors, unexpected_errors, count_errors,
             "issue_ready", ready_errors, "timeout", timed_out);
  endtask

  task automatic report_timeout(input string what);
    timed_out = 1'b1;
    $display("Timed out at %0t waiting for %s", $time, what);
  endtask

  task automatic wait_reg(input warp_num_t w, input reg_num_t r);
    int waited;
    waited = 0;
    while (pend[w][r] && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("a register writeback");
    end
  endtask

  task automatic wait_all_writebacks();
    int waited;
    waited = 0;
    while (wb_count < exp_count && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("all outstanding writebacks");
    end
  endtask

  // The store is the only LSU instruction in flight when this is called
  task automatic wait_store_drain();
    int waited;
    waited = 0;
    while (!u_dut.lsu_dispatch && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("the store to dispatch");
    end
    @(negedge clk);
    while (u_dut.lsu_busy && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("the store to complete");
    end
  endtask

  task automatic issue(input warp_num_t w, input opcode_t op, input reg_num_t rd,
                       input reg_num_t rs1, input reg_num_t rs2, input logic [15:0] imm);
    word_t a;
    word_t b;
    word_t value;
    int    addr;
    int    waited;
    wait_reg(w, rs1);
    wait_reg(w, rs2);
    wait_reg(w, rd);
    waited = 0;
    while (!issue_ready && !timed_out) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_timeout("issue_ready");
    end
    if (timed_out) begin
      return;
    end
    a    = model_reg[w][rs1];
    b    = model_reg[w][rs2];
    addr = int'((a + sign_extend16(imm)) % MEM_WORDS);
    case (op)
      OP_LI:   value = sign_extend16(imm);
      OP_ADD:  value = a + b;
      OP_SUB:  value = a - b;
      OP_AND:  value = a & b;
      OP_XOR:  value = a ^ b;
      OP_LOAD: value = model_mem[addr];
      default: value = '0;
    endcase
    if (op == OP_STORE) begin
      model_mem[addr] = b;
    end else begin
      model_reg[w][rd] = value;
      pend[w][rd]      = 1'b1;
      exp_count++;
    end
    issue_inst.warp   = w;
    issue_inst.opcode = op;
    issue_inst.rd     = rd;
    issue_inst.rs1    = rs1;
    issue_inst.rs2    = rs2;
    issue_inst.imm    = imm;
    issue_valid       = 1'b1;
    @(negedge clk);
    issue_valid = 1'b0;
  endtask

  initial begin
    warp_num_t w;
    logic [31:0] r;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_inst  = '0;
    for (int i = 0; i < 4; i++) begin
      for (int j = 0; j < 32; j++) begin
        model_reg[i][j] = '0;
        pend[i][j]      = 1'b0;
      end
    end
    for (int i = 0; i < MEM_WORDS; i++) begin
      model_mem[i] = '0;
    end
    repeat (3) @(negedge clk);
    rst_n = 1'b1;

    ready_after_reset: assert (issue_ready)
      else begin
        ready_errors++;
        $display("issue_ready is low after reset although the collector is empty");
      end

    // li with a negative immediate, then the source set of every warp
    issue(2'd0, OP_LI, 5'd1, 5'd0, 5'd0, 16'h8001);
    for (int i = 0; i < 4; i++) begin
      for (int k = 0; k < 7; k++) begin
        issue(warp_num_t'(i), OP_LI, src_regs[k], 5'd0, 5'd0, 16'(next_rand() >> 16));
      end
    end
    for (int i = 0; i < 4; i++) begin
      issue(warp_num_t'(i), OP_ADD, 5'd6, 5'd1, 5'd0, '0);
      issue(warp_num_t'(i), OP_ADD, 5'd7, 5'd0, 5'd0, '0);
      issue(warp_num_t'(i), OP_XOR, 5'd8, 5'd0, 5'd0, '0);
    end

    // Same-bank pairs, then random two-source operations
    issue(2'd0, OP_ADD, 5'd12, 5'd1, 5'd2, '0);
    issue(2'd1, OP_SUB, 5'd13, 5'd9, 5'd10, '0);
    for (int i = 0; i < 24; i++) begin
      w = warp_num_t'(next_rand());
      issue(w, alu_ops[next_rand() % 4], reg_num_t'(11 + i % 5),
            src_regs[next_rand() % 7], src_regs[next_rand() % 7], '0);
    end

    // Same register number, four warps
    for (int i = 0; i < 4; i++) begin
      issue(warp_num_t'(i), OP_LI, 5'd4, 5'd0, 5'd0, 16'(16'h0100 * (i + 1) + i));
    end
    for (int i = 0; i < 4; i++) begin
      issue(warp_num_t'(i), OP_ADD, 5'd5, 5'd4, 5'd4, '0);
    end

    wait_all_writebacks();
    issue(2'd2, OP_STORE, 5'd0, 5'd0, 5'd9, 16'd5);
    wait_store_drain();
    issue(2'd3, OP_LOAD, 5'd14, 5'd0, 5'd0, 16'd5);
    wait_all_writebacks();
    issue(2'd1, OP_STORE, 5'd0, 5'd1, 5'd2, 16'hfffe);
    wait_store_drain();
    issue(2'd1, OP_LOAD, 5'd15, 5'd1, 5'd0, 16'hfffe);

    // Burst of stores to the upper half of memory and loads from the lower half
    wait_all_writebacks();
    ready_low_seen = 1'b0;
    for (int i = 0; i < 24; i++) begin
      w = warp_num_t'(i % 4);
      r = next_rand() % 7;
      if (r == 5) begin
        issue(w, OP_STORE, 5'd0, 5'd0, src_regs[next_rand() % 7], 16'(32 + next_rand() % 32));
      end else if (r == 6) begin
        issue(w, OP_LOAD, reg_num_t'(26 + i / 4), 5'd0, 5'd0, 16'(next_rand() % 32));
      end else if (r == 4) begin
        issue(w, OP_LI, reg_num_t'(26 + i / 4), 5'd0, 5'd0, 16'(next_rand() >> 16));
      end else begin
        issue(w, alu_ops[r], reg_num_t'(26 + i / 4),
              src_regs[next_rand() % 7], src_regs[next_rand() % 7], '0);
      end
    end
    wait_all_writebacks();

    writeback_count: assert (wb_count == exp_count)
      else begin
        count_errors++;
        $display("Saw %0d writebacks for %0d non-store instructions", wb_count, exp_count);
      end

    backpressure_seen: assert (ready_low_seen)
      else begin
        ready_errors++;
        $display("issue_ready never dropped while the burst outpaced the ALU");
      end

    print_counts();
    if (!timed_out &&
        value_errors + unexpected_errors + count_errors + ready_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

/* all.f */
gpu_isa_pkg.sv
gpu_pipe_pkg.sv
inst_decoder.sv
operand_collector.sv
register_banks.sv
alu_unit.sv
load_store_unit.sv
writeback_arbiter.sv
gpu_operand_top.sv
tb_gpu_operand.sv
